/* Makefile */
# Verilator lint and simulation for the Apple II card glue

VERILATOR ?= verilator
TB_TOP    ?= a2_card_glue_tb
FILELIST  ?= a2_card_glue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* a2_card_glue.f */
+incdir+hw
hw/a2_glue_pkg.sv
hw/bus_edge_sync.sv
hw/card_response_arbiter.sv
hw/audio_mixer.sv
hw/scanline_dimmer.sv
hw/a2_card_glue.sv
testbench/a2_card_glue_properties.sv
testbench/a2_card_glue_tb.sv

/* hw/a2_card_glue.sv */
/*
 * Apple II slot card bus glue
 * Recovers phi1 and 7M, arbitrates card read data and interrupts onto
 * the bus, mixes card audio and dims odd scanlines of the video out
 */

`include "a2_glue_defs.svh"

module a2_card_glue
    import a2_glue_pkg::*;
#(
    parameter bit SCANLINES_ENABLE = 0,
    parameter bit APPLE_SPEAKER_ENABLE = 0,
    parameter bit BUS_DATA_OUT_ENABLE = 1,
    parameter bit IRQ_OUT_ENABLE = 1
) (
    input  logic                      clk_logic_w,
    input  logic                      reset_i,

    // Apple clocks, asynchronous to clk_logic_w
    input  logic                      a2_phi1_i,
    input  logic                      a2_7m_i,

    // Card responses and latched bus data
    input  card_resp_arr_t            cards_i,
    input  logic [`A2_DATA_W-1:0]     bus_data_i,

    // Audio sources
    input  logic [`A2_AUDIO_W-1:0]    sprite_audio_i,
    input  logic [`A2_MB_AUDIO_W-1:0] mock_audio_i,
    input  logic                      speaker_i,

    input  logic [3:0]                dip_switches_n_i,

    // Outgoing video
    input  rgb_t                      pixel_i,
    input  logic [`A2_SCREEN_Y_W-1:0] screen_y_i,

    // phi1 edges give the 2M strobe, 7M edges the 14M strobe
    output edge_strobe_t              phi1_o,
    output edge_strobe_t              clk7m_o,

    output logic                      data_out_en_o,
    output logic [`A2_DATA_W-1:0]     data_out_o,
    output logic                      irq_n_o,
    output logic [`A2_AUDIO_W-1:0]    audio_o,
    output rgb_t                      pixel_o
);

    bus_edge_sync sync_phi1 (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .async_i     (a2_phi1_i),
        .strobe_o    (phi1_o)
    );

    bus_edge_sync sync_7m (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .async_i     (a2_7m_i),
        .strobe_o    (clk7m_o)
    );

    card_response_arbiter #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) arbiter_i (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (reset_i),
        .cards_i       (cards_i),
        .bus_data_i    (bus_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer #(
        .APPLE_SPEAKER_ENABLE (APPLE_SPEAKER_ENABLE)
    ) mixer_i (
        .clk_logic_w      (clk_logic_w),
        .reset_i          (reset_i),
        .sprite_audio_i   (sprite_audio_i),
        .mock_audio_i     (mock_audio_i),
        .speaker_i        (speaker_i),
        .dip_switches_n_i (dip_switches_n_i),
        .audio_o          (audio_o)
    );

    scanline_dimmer #(
        .SCANLINES_ENABLE (SCANLINES_ENABLE)
    ) dimmer_i (
        .clk_logic_w      (clk_logic_w),
        .reset_i          (reset_i),
        .pixel_i          (pixel_i),
        .screen_y_i       (screen_y_i),
        .dip_switches_n_i (dip_switches_n_i),
        .pixel_o          (pixel_o)
    );

endmodule

/* hw/a2_glue_defs.svh */
/*
 * Apple II card glue constants
 * Bus, audio and video widths, mixer shift amounts and DIP switch bits
 */

`ifndef A2_GLUE_DEFS_SVH
`define A2_GLUE_DEFS_SVH

// Apple bus
`define A2_DATA_W 8
`define A2_NUM_CARDS 4

// Audio sample widths
`define A2_AUDIO_W 16
`define A2_MB_AUDIO_W 10

// Mixer weights as left shifts
`define A2_MB_SHIFT 5
`define A2_SPK_SHIFT 13

// Video
`define A2_COLOR_W 8
`define A2_SCREEN_Y_W 10

// Flops ahead of the edge register
`define A2_SYNC_STAGES 2

// DIP switch bits, switches read low when on
`define A2_DIP_SCANLINES 0
`define A2_DIP_SPEAKER 1

`endif

/* hw/a2_glue_pkg.sv */
/*
 * Apple II card glue types
 * Card bus responses, card priority order, pixels and recovered
 * clock strobes shared by the glue blocks
 */

`include "a2_glue_defs.svh"

package a2_glue_pkg;

    // One card's answer to a bus read
    typedef struct packed {
        logic                   rd_en;
        logic [`A2_DATA_W-1:0]  data;
        logic                   irq_n;
    } card_resp_t;

    // Slot order, lowest value wins the bus
    typedef enum logic [1:0] {
        CARD_SERIAL = 2'd0,
        CARD_SPRITE = 2'd1,
        CARD_MOCK   = 2'd2,
        CARD_DISK   = 2'd3
    } card_idx_e;

    // Indexed by card_idx_e
    typedef card_resp_t [`A2_NUM_CARDS-1:0] card_resp_arr_t;

    typedef struct packed {
        logic [`A2_COLOR_W-1:0] r;
        logic [`A2_COLOR_W-1:0] g;
        logic [`A2_COLOR_W-1:0] b;
    } rgb_t;

    // Level of a recovered clock and its single cycle edge strobes
    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
        logic any;
    } edge_strobe_t;

endpackage

/* hw/audio_mixer.sv */
/*
 * Audio mixer
 * Sums the sprite, Mockingboard and speaker sources into one
 * 16-bit sample, wrapping on overflow, one cycle of latency
 */

`include "a2_glue_defs.svh"

module audio_mixer #(
    parameter bit APPLE_SPEAKER_ENABLE = 0
) (
    input  logic                      clk_logic_w,
    input  logic                      reset_i,
    input  logic [`A2_AUDIO_W-1:0]    sprite_audio_i,
    input  logic [`A2_MB_AUDIO_W-1:0] mock_audio_i,
    input  logic                      speaker_i,
    input  logic [3:0]                dip_switches_n_i,
    output logic [`A2_AUDIO_W-1:0]    audio_o
);

    logic                   spk_en_w;
    logic [`A2_AUDIO_W-1:0] mb_term_w;
    logic [`A2_AUDIO_W-1:0] spk_term_w;
    logic [`A2_AUDIO_W-1:0] sum_w;
    logic [`A2_AUDIO_W-1:0] audio_q;

    // Speaker switch is active low
    assign spk_en_w = APPLE_SPEAKER_ENABLE | ~dip_switches_n_i[`A2_DIP_SPEAKER];

    // Scale the narrower sources up into the sample range
    assign mb_term_w  = `A2_AUDIO_W'(mock_audio_i) << `A2_MB_SHIFT;
    assign spk_term_w = `A2_AUDIO_W'(speaker_i & spk_en_w) << `A2_SPK_SHIFT;

    // Modulo 2^16, carries out of the top are dropped
    assign sum_w = sprite_audio_i + mb_term_w + spk_term_w;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            audio_q <= '0;
        end else begin
            audio_q <= sum_w;
        end
    end

    assign audio_o = audio_q;

endmodule

/* hw/bus_edge_sync.sv */
/*
 * Apple clock recovery
 * Brings one asynchronous Apple clock into the logic clock domain and
 * derives its level plus rise, fall and either-edge strobes
 */

`include "a2_glue_defs.svh"

module bus_edge_sync
    import a2_glue_pkg::*;
(
    input  logic         clk_logic_w,
    input  logic         reset_i,
    input  logic         async_i,
    output edge_strobe_t strobe_o
);

    localparam int STAGES = `A2_SYNC_STAGES;

    logic [STAGES-1:0] sync_q;
    logic              sync_w;
    edge_strobe_t      strobe_q;

    // Metastability chain, oldest sample at the top
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], async_i};
        end
    end

    assign sync_w = sync_q[STAGES-1];

    // Level register doubles as the history flop for edge detection
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            strobe_q <= '0;
        end else begin
            strobe_q.level <= sync_w;
            strobe_q.rise  <= sync_w & ~strobe_q.level;
            strobe_q.fall  <= ~sync_w & strobe_q.level;
            strobe_q.any   <= sync_w ^ strobe_q.level;
        end
    end

    // Strobes line up with the cycle the new level first shows
    assign strobe_o = strobe_q;

endmodule

/* hw/card_response_arbiter.sv */
/*
 * Card response arbiter
 * Picks the read data of the highest priority card onto the bus data
 * out port and merges the card interrupts, one cycle of latency
 */

`include "a2_glue_defs.svh"

module card_response_arbiter
    import a2_glue_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1,
    parameter bit IRQ_OUT_ENABLE = 1
) (
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  card_resp_arr_t        cards_i,
    input  logic [`A2_DATA_W-1:0] bus_data_i,
    output logic                  data_out_en_o,
    output logic [`A2_DATA_W-1:0] data_out_o,
    output logic                  irq_n_o
);

    card_idx_e             winner_w;
    logic                  any_rd_w;
    logic                  any_irq_w;
    logic [`A2_DATA_W-1:0] data_sel_w;

    logic                  data_out_en_q;
    logic [`A2_DATA_W-1:0] data_out_q;
    logic                  irq_n_q;

    // Walk from the lowest priority up so the lowest index ends up winning
    always_comb begin
        winner_w  = CARD_DISK;
        any_rd_w  = 1'b0;
        any_irq_w = 1'b0;
        for (int i = `A2_NUM_CARDS - 1; i >= 0; i--) begin
            if (cards_i[i].rd_en) begin
                winner_w = card_idx_e'(i);
                any_rd_w = 1'b1;
            end
            any_irq_w = any_irq_w | ~cards_i[i].irq_n;
        end
    end

    // Latched bus data passes through when no card answers
    assign data_sel_w = any_rd_w ? cards_i[winner_w].data : bus_data_i;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            data_out_en_q <= 1'b0;
            data_out_q    <= '0;
            irq_n_q       <= 1'b1;
        end else begin
            data_out_en_q <= any_rd_w & BUS_DATA_OUT_ENABLE;
            data_out_q    <= data_sel_w;
            // Interrupt line stays released if driving it is not allowed
            irq_n_q       <= ~(any_irq_w & IRQ_OUT_ENABLE);
        end
    end

    assign data_out_en_o = data_out_en_q;
    assign data_out_o    = data_out_q;
    assign irq_n_o       = irq_n_q;

endmodule

/* hw/scanline_dimmer.sv */
/*
 * Scanline dimmer
 * Halves every colour channel on odd screen lines when enabled,
 * one cycle of latency
 */

`include "a2_glue_defs.svh"

module scanline_dimmer
    import a2_glue_pkg::*;
#(
    parameter bit SCANLINES_ENABLE = 0
) (
    input  logic                      clk_logic_w,
    input  logic                      reset_i,
    input  rgb_t                      pixel_i,
    input  logic [`A2_SCREEN_Y_W-1:0] screen_y_i,
    input  logic [3:0]                dip_switches_n_i,
    output rgb_t                      pixel_o
);

    logic dim_en_w;
    logic dim_line_w;
    rgb_t dimmed_w;
    rgb_t pixel_q;

    // Scanline switch is active low
    assign dim_en_w   = SCANLINES_ENABLE | ~dip_switches_n_i[`A2_DIP_SCANLINES];
    assign dim_line_w = dim_en_w & screen_y_i[0];

    // Half brightness, zero shifted into the top bit
    assign dimmed_w.r = pixel_i.r >> 1;
    assign dimmed_w.g = pixel_i.g >> 1;
    assign dimmed_w.b = pixel_i.b >> 1;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            pixel_q <= '0;
        end else begin
            pixel_q <= dim_line_w ? dimmed_w : pixel_i;
        end
    end

    assign pixel_o = pixel_q;

endmodule

/* testbench/a2_card_glue_properties.sv */
/*
 * Concurrent checks on the card glue outputs
 * Recovered clock strobes stay well formed and the bus driver
 * stays off through reset
 */

module a2_card_glue_properties
    import a2_glue_pkg::*;
(
    input logic         clk_logic_w,
    input logic         reset_i,
    input edge_strobe_t phi1_i,
    input edge_strobe_t clk7m_i,
    input logic         data_out_en_i
);

    phi1_rise_fall_a: assert property (
        @(posedge clk_logic_w) disable iff (reset_i) !(phi1_i.rise && phi1_i.fall)
    ) else $error("phi1 rise and fall strobes high together");

    clk7m_rise_fall_a: assert property (
        @(posedge clk_logic_w) disable iff (reset_i) !(clk7m_i.rise && clk7m_i.fall)
    ) else $error("7M rise and fall strobes high together");

    // One pulse per edge
    phi1_rise_single_a: assert property (
        @(posedge clk_logic_w) disable iff (reset_i) phi1_i.rise |=> !phi1_i.rise
    ) else $error("phi1 rise strobe high on two cycles in a row");

    clk7m_rise_single_a: assert property (
        @(posedge clk_logic_w) disable iff (reset_i) clk7m_i.rise |=> !clk7m_i.rise
    ) else $error("7M rise strobe high on two cycles in a row");

    // Registered output shows its old value in the first reset cycle
    bus_off_in_reset_a: assert property (
        @(posedge clk_logic_w) reset_i && $past(reset_i) |-> !data_out_en_i
    ) else $error("bus data out enabled during reset");

endmodule

bind a2_card_glue a2_card_glue_properties props_i (
    .clk_logic_w   (clk_logic_w),
    .reset_i       (reset_i),
    .phi1_i        (phi1_o),
    .clk7m_i       (clk7m_o),
    .data_out_en_i (data_out_en_o)
);

/* testbench/a2_card_glue_tb.sv */
/*
 * Testbench for the Apple II card glue
 * Replays trace vectors through the bus, audio and video paths, checks
 * the reset values and checks phi1 and 7M recovery against driven waveforms
 */

`include "a2_glue_defs.svh"

module a2_card_glue_tb
    import a2_glue_pkg::*;
();

    localparam int NAME_W    = 8 * 32;
    localparam int LINE_W    = 8 * 200;
    localparam int CLK_EDGES = 30;

    typedef struct packed {
        logic [NAME_W-1:0]         name;
        card_resp_arr_t            cards;
        logic [`A2_DATA_W-1:0]     bus;
        logic [`A2_AUDIO_W-1:0]    sprite;
        logic [`A2_MB_AUDIO_W-1:0] mock;
        logic                      spk;
        logic [3:0]                dip;
        rgb_t                      pixel;
        logic [`A2_SCREEN_Y_W-1:0] y;
        logic                      exp_en;
        logic [`A2_DATA_W-1:0]     exp_data;
        logic                      exp_irq_n;
        logic [`A2_AUDIO_W-1:0]    exp_audio;
        rgb_t                      exp_pixel;
    } trace_vec_t;

    logic                      clk_logic_w;
    logic                      reset_i;
    logic                      a2_phi1;
    logic                      a2_7m;
    card_resp_arr_t            cards;
    logic [`A2_DATA_W-1:0]     bus_data;
    logic [`A2_AUDIO_W-1:0]    sprite_audio;
    logic [`A2_MB_AUDIO_W-1:0] mock_audio;
    logic                      speaker;
    logic [3:0]                dip_switches_n;
    rgb_t                      pixel_in;
    logic [`A2_SCREEN_Y_W-1:0] screen_y;
    edge_strobe_t              phi1_strobe;
    edge_strobe_t              clk7m_strobe;
    logic                      data_out_en;
    logic [`A2_DATA_W-1:0]     data_out;
    logic                      irq_n;
    logic [`A2_AUDIO_W-1:0]    audio;
    rgb_t                      pixel_out;

    trace_vec_t vecs[$];
    int         cycle_limit = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         rises_seen = 0;
    int         falls_seen = 0;
    int         anys_seen = 0;
    int         rises_7m_seen = 0;
    int         falls_7m_seen = 0;
    int         anys_7m_seen = 0;
    int         level_errors = 0;
    logic [2:0] phi1_hist = '0;
    logic [2:0] clk7m_hist = '0;

    a2_card_glue dut_i (
        .clk_logic_w      (clk_logic_w),
        .reset_i          (reset_i),
        .a2_phi1_i        (a2_phi1),
        .a2_7m_i          (a2_7m),
        .cards_i          (cards),
        .bus_data_i       (bus_data),
        .sprite_audio_i   (sprite_audio),
        .mock_audio_i     (mock_audio),
        .speaker_i        (speaker),
        .dip_switches_n_i (dip_switches_n),
        .pixel_i          (pixel_in),
        .screen_y_i       (screen_y),
        .phi1_o           (phi1_strobe),
        .clk7m_o          (clk7m_strobe),
        .data_out_en_o    (data_out_en),
        .data_out_o       (data_out),
        .irq_n_o          (irq_n),
        .audio_o          (audio),
        .pixel_o          (pixel_out)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever begin
            #10 clk_logic_w = ~clk_logic_w;
        end
    end

    // Level lags the pin by three cycles
    // Each strobe pulse is counted once
    always @(negedge clk_logic_w) begin
        if (!reset_i) begin
            if (phi1_strobe.rise) rises_seen++;
            if (phi1_strobe.fall) falls_seen++;
            if (phi1_strobe.any) anys_seen++;
            if (clk7m_strobe.rise) rises_7m_seen++;
            if (clk7m_strobe.fall) falls_7m_seen++;
            if (clk7m_strobe.any) anys_7m_seen++;
            assert (phi1_strobe.level == phi1_hist[2]) else begin
                $display("FAILED clock_level expected %0b actual %0b",
                         phi1_hist[2], phi1_strobe.level);
                level_errors++;
            end
            assert (clk7m_strobe.level == clk7m_hist[2]) else begin
                $display("FAILED clock_7m_level expected %0b actual %0b",
                         clk7m_hist[2], clk7m_strobe.level);
                level_errors++;
            end
        end
        phi1_hist = {phi1_hist[1:0], a2_phi1};
        clk7m_hist = {clk7m_hist[1:0], a2_7m};
    end

    task automatic check_value(input logic [NAME_W-1:0] test, input logic [8*12-1:0] what,
                               input logic [31:0] expected, input logic [31:0] actual,
                               inout int bad);
        assert (actual == expected) else begin
            $display("FAILED %0s %0s expected %0h actual %0h", test, what, expected, actual);
            bad++;
        end
    endtask

    task automatic report_test(input logic [NAME_W-1:0] test, input int bad);
        if (bad == 0) begin
            pass_count++;
            $display("test %0s passed", test);
        end else begin
            fail_count++;
            $display("test %0s failed with %0d mismatches", test, bad);
        end
    endtask

    task automatic load_trace();
        int                fd;
        int                n;
        logic [LINE_W-1:0] line;
        logic [NAME_W-1:0] tok;
        logic [31:0]       f [18];
        trace_vec_t        v;
        fd = $fopen("testbench/a2_card_glue_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file testbench/a2_card_glue_trace.txt could not be opened");
            fail_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tok);
            if (n < 1 || tok == {{31{8'h00}}, "#"}) continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tok, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (n != 19) begin
                $display("trace line %0s is malformed, %0d of 19 fields read", tok, n);
                fail_count++;
                continue;
            end
            v.name = tok;
            // Masks carry one bit per card slot
            for (int i = 0; i < `A2_NUM_CARDS; i++) begin
                v.cards[i].rd_en = f[0][i];
                v.cards[i].irq_n = f[1][i];
                v.cards[i].data  = f[2 + i][`A2_DATA_W-1:0];
            end
            v.bus       = f[6][`A2_DATA_W-1:0];
            v.sprite    = f[7][`A2_AUDIO_W-1:0];
            v.mock      = f[8][`A2_MB_AUDIO_W-1:0];
            v.spk       = f[9][0];
            v.dip       = f[10][3:0];
            v.pixel     = f[11][23:0];
            v.y         = f[12][`A2_SCREEN_Y_W-1:0];
            v.exp_en    = f[13][0];
            v.exp_data  = f[14][`A2_DATA_W-1:0];
            v.exp_irq_n = f[15][0];
            v.exp_audio = f[16][`A2_AUDIO_W-1:0];
            v.exp_pixel = f[17][23:0];
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("trace file holds no usable vectors");
            fail_count++;
        end
    endtask

    task automatic check_reset_values();
        int bad;
        bad = 0;
        check_value("reset_values", "data_out_en", 32'h0, 32'(data_out_en), bad);
        check_value("reset_values", "data_out", 32'h0, 32'(data_out), bad);
        check_value("reset_values", "irq_n", 32'h1, 32'(irq_n), bad);
        check_value("reset_values", "audio", 32'h0, 32'(audio), bad);
        check_value("reset_values", "pixel", 32'h0, 32'(pixel_out), bad);
        report_test("reset_values", bad);
    endtask

    task automatic run_vector(input trace_vec_t v);
        int bad;
        bad = 0;
        @(posedge clk_logic_w);
        cards          <= v.cards;
        bus_data       <= v.bus;
        sprite_audio   <= v.sprite;
        mock_audio     <= v.mock;
        speaker        <= v.spk;
        dip_switches_n <= v.dip;
        pixel_in       <= v.pixel;
        screen_y       <= v.y;
        // Every output path is one register deep
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_value(v.name, "data_out_en", 32'(v.exp_en), 32'(data_out_en), bad);
        check_value(v.name, "data_out", 32'(v.exp_data), 32'(data_out), bad);
        check_value(v.name, "irq_n", 32'(v.exp_irq_n), 32'(irq_n), bad);
        check_value(v.name, "audio", 32'(v.exp_audio), 32'(audio), bad);
        check_value(v.name, "pixel", 32'(v.exp_pixel), 32'(pixel_out), bad);
        report_test(v.name, bad);
    endtask

    task automatic run_clock_recovery();
        int   bad;
        int   half;
        int   rises_driven;
        int   falls_driven;
        int   rises_7m_driven;
        int   falls_7m_driven;
        logic level;
        logic level_7m;
        bad = 0;
        rises_driven = 0;
        falls_driven = 0;
        rises_7m_driven = 0;
        falls_7m_driven = 0;
        level = 1'b0;
        level_7m = 1'b0;
        for (int e = 0; e < CLK_EDGES; e++) begin
            half = 4 + int'($urandom % 6);
            // 7M toggles on every logic clock while phi1 holds
            repeat (half) begin
                @(posedge clk_logic_w);
                level_7m = ~level_7m;
                a2_7m <= level_7m;
                if (level_7m) rises_7m_driven++;
                else falls_7m_driven++;
            end
            level = ~level;
            a2_phi1 <= level;
            if (level) rises_driven++;
            else falls_driven++;
        end
        // Let the last edge through the synchronizer
        repeat (5) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_value("clock_recovery", "rise_count", rises_driven, rises_seen, bad);
        check_value("clock_recovery", "fall_count", falls_driven, falls_seen, bad);
        check_value("clock_recovery", "edge_count", rises_driven + falls_driven,
                    anys_seen, bad);
        check_value("clock_recovery", "rise_7m", rises_7m_driven, rises_7m_seen, bad);
        check_value("clock_recovery", "fall_7m", falls_7m_driven, falls_7m_seen, bad);
        check_value("clock_recovery", "edge_7m", rises_7m_driven + falls_7m_driven,
                    anys_7m_seen, bad);
        report_test("clock_recovery", bad + level_errors);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk_logic_w);
        while (cycles < cycle_limit) begin
            @(posedge clk_logic_w);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset_i        <= 1'b1;
        a2_phi1        <= 1'b0;
        a2_7m          <= 1'b0;
        // Cards reading and interrupting, other paths busy, all through reset
        cards          <= {`A2_NUM_CARDS{card_resp_t'{1'b1, 8'ha5, 1'b0}}};
        bus_data       <= 8'h5a;
        sprite_audio   <= 16'h1234;
        mock_audio     <= 10'h3ff;
        speaker        <= 1'b1;
        dip_switches_n <= 4'h0;
        pixel_in       <= 24'hffffff;
        screen_y       <= 10'h001;
        void'($urandom(32'h6d8b160a));
        load_trace();
        cycle_limit = 4 * vecs.size() + CLK_EDGES * 10 + 100;
        repeat (7) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_reset_values();
        @(posedge clk_logic_w);
        reset_i <= 1'b0;
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        run_clock_recovery();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* testbench/a2_card_glue_trace.txt */
# name rd_mask irq_n_mask d0 d1 d2 d3 bus sprite mock spk dip pixel screen_y
# expected: data_out_en data_out irq_n audio pixel   (masks: bit i is card i)
prio_all      f f 11 22 33 44 55 0000 000 0 f 102030 000 1 11 1 0000 102030
prio_mock     c f a1 b2 c3 d4 66 1234 000 0 f ffffff 001 1 c3 1 1234 ffffff
prio_disk     8 f 01 02 03 04 77 0000 001 0 f 808080 002 1 04 1 0020 808080
prio_ser_disk 9 f 5a 00 00 a5 00 0000 000 0 f 000000 000 1 5a 1 0000 000000
prio_spr_disk a f 00 e1 00 e3 00 0000 000 0 f 000000 000 1 e1 1 0000 000000
pass_none     0 f 12 34 56 78 c7 0000 000 0 f 000000 000 0 c7 1 0000 000000
pass_zero     0 f ff ff ff ff 00 0000 000 0 f 000000 000 0 00 1 0000 000000
irq_serial    0 e 00 00 00 00 3c 0000 000 0 f 000000 000 0 3c 0 0000 000000
irq_disk      0 7 00 00 00 00 3d 0000 000 0 f 000000 000 0 3d 0 0000 000000
irq_all_read  2 0 00 99 00 00 3e 0000 000 0 f 000000 000 1 99 0 0000 000000
audio_mock    0 f 00 00 00 00 00 0100 3ff 0 f 000000 000 0 00 1 80e0 000000
audio_spk_off 0 f 00 00 00 00 00 0000 000 1 f 000000 000 0 00 1 0000 000000
audio_spk_on  0 f 00 00 00 00 00 0001 000 1 d 000000 000 0 00 1 2001 000000
audio_wrap    0 f 00 00 00 00 00 ffff 001 1 d 000000 000 0 00 1 201f 000000
audio_mix     0 f 00 00 00 00 00 8000 155 0 e 0a0b0c 000 0 00 1 aaa0 0a0b0c
scan_odd      0 f 00 00 00 00 00 0000 000 0 e ff8001 001 0 00 1 0000 7f4000
scan_even     0 f 00 00 00 00 00 0000 000 0 e ff8001 002 0 00 1 0000 ff8001
scan_dip_off  0 f 00 00 00 00 00 0000 000 0 f 123456 003 0 00 1 0000 123456
scan_spk_odd  0 f 00 00 00 00 00 0000 000 1 c 0a0b0c 3ff 0 00 1 2000 050506
